//--- src/tracker_cfg.svh
`ifndef TRACKER_CFG_SVH
`define TRACKER_CFG_SVH

// ============================================================================
// camera front end configuration
// ============================================================================

// column count width, enough for 1280 active columns
`define TRACKER_HCOUNT_W 11

// row count width, enough for 720 active rows
`define TRACKER_VCOUNT_W 10

// flip-flops per camera pin before the signal is trusted
`define TRACKER_SYNC_STAGES 2

// fixed ceiling of the green window, 8-bit scale
`define TRACKER_GREEN_CEIL 8'hF0

// fewer player pixels than this and the frame has no usable centroid
`define TRACKER_MIN_PIXELS 16

// width of the coordinate sums and the pixel count
`define TRACKER_SUM_W 32

`endif

//--- src/tracker_pkg.sv
`default_nettype none

`include "tracker_cfg.svh"

package tracker_pkg;

  // color view of one camera pixel, rgb565
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // byte view of the same word
  // the camera sends the high byte first
  typedef struct packed {
    logic [7:0] first_byte;
    logic [7:0] second_byte;
  } cam_byte_pair_t;

  // written as bytes by the pixel builder, read as colors by the keyer
  typedef union packed {
    rgb565_t        color;
    cam_byte_pair_t bytes;
  } cam_pixel_u;

  // pixel position counts
  typedef logic [`TRACKER_HCOUNT_W-1:0] hcount_t;
  typedef logic [`TRACKER_VCOUNT_W-1:0] vcount_t;

endpackage

`default_nettype wire

//--- src/cam_input_sync.sv
`default_nettype none

`include "tracker_cfg.svh"

module cam_input_sync (
  input  wire        clk_camera,
  input  wire        recent_reset,
  input  wire  [7:0] cam_data_i,
  input  wire        cam_pclk_i,
  input  wire        cam_hsync_i,
  input  wire        cam_vsync_i,
  output logic [7:0] sync_data_o,
  output logic       pclk_rise_o,
  output logic       sync_hsync_o,
  output logic       sync_vsync_o
);

  localparam int STAGES = `TRACKER_SYNC_STAGES;

  // stage 0 samples the pin, last stage feeds the pipeline
  logic [7:0]        data_sync [STAGES];
  logic [STAGES-1:0] pclk_sync;
  logic [STAGES-1:0] hsync_sync;
  logic [STAGES-1:0] vsync_sync;
  // last synchronized pclk, for the edge detector
  logic              pclk_prev;

  // data bus carries no control meaning, it only needs to settle
  always_ff @(posedge clk_camera) begin
    data_sync[0] <= cam_data_i;
    for (int i = 1; i < STAGES; i++) begin
      data_sync[i] <= data_sync[i-1];
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sync   <= '0;
      hsync_sync  <= '0;
      vsync_sync  <= '0;
      pclk_prev   <= 1'b0;
      pclk_rise_o <= 1'b0;
    end else begin
      pclk_sync   <= {pclk_sync[STAGES-2:0], cam_pclk_i};
      hsync_sync  <= {hsync_sync[STAGES-2:0], cam_hsync_i};
      vsync_sync  <= {vsync_sync[STAGES-2:0], cam_vsync_i};
      pclk_prev   <= pclk_sync[STAGES-1];
      // one cycle pulse per camera pixel clock rising edge
      pclk_rise_o <= pclk_sync[STAGES-1] & ~pclk_prev;
    end
  end

  assign sync_data_o  = data_sync[STAGES-1];
  assign sync_hsync_o = hsync_sync[STAGES-1];
  assign sync_vsync_o = vsync_sync[STAGES-1];

endmodule

`default_nettype wire

//--- src/pixel_reconstruct.sv
`default_nettype none

module pixel_reconstruct (
  input  wire                     clk_camera,
  input  wire                     recent_reset,
  input  wire  [7:0]              sync_data_i,
  input  wire                     pclk_rise_i,
  input  wire                     sync_hsync_i,
  input  wire                     sync_vsync_i,
  output logic                    pix_valid_o,
  output tracker_pkg::cam_pixel_u pix_data_o,
  output tracker_pkg::hcount_t    pix_hcount_o,
  output tracker_pkg::vcount_t    pix_vcount_o,
  output logic                    frame_end_o
);

  import tracker_pkg::*;

  // sync edge history
  logic       hsync_prev;
  logic       vsync_prev;
  logic       line_start;
  logic       line_end;
  logic       frame_start;
  // byte accepted this cycle
  logic       byte_take;
  // high once the first byte of a pair is held
  logic       byte_phase;
  logic [7:0] first_byte;
  // position of the next pixel to come out
  hcount_t    col;
  vcount_t    row;
  logic       pair_done;

  assign line_start  = sync_hsync_i & ~hsync_prev;
  assign line_end    = ~sync_hsync_i & hsync_prev;
  assign frame_start = sync_vsync_i & ~vsync_prev;
  // bytes only count inside an active line and outside vertical sync
  assign byte_take   = pclk_rise_i & sync_hsync_i & ~sync_vsync_i;
  // a line start restarts the phase, so a byte there is always a first byte
  assign pair_done   = byte_take & byte_phase & ~line_start;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      hsync_prev  <= 1'b0;
      vsync_prev  <= 1'b0;
      byte_phase  <= 1'b0;
      col         <= '0;
      row         <= '0;
      pix_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      hsync_prev  <= sync_hsync_i;
      vsync_prev  <= sync_vsync_i;
      pix_valid_o <= pair_done;
      frame_end_o <= frame_start;
      if (byte_take) begin
        byte_phase <= ~pair_done;
      end else if (line_start) begin
        byte_phase <= 1'b0;
      end
      // column restarts per line, steps once per finished pixel
      if (line_start) begin
        col <= '0;
      end else if (pair_done) begin
        col <= col + 1'b1;
      end
      // row steps at the end of each line
      if (frame_start) begin
        row <= '0;
      end else if (line_end) begin
        row <= row + 1'b1;
      end
    end
  end

  // pixel word and its position, written through the byte view
  always_ff @(posedge clk_camera) begin
    if (byte_take && !pair_done) begin
      first_byte <= sync_data_i;
    end
    if (pair_done) begin
      pix_data_o.bytes.first_byte  <= first_byte;
      pix_data_o.bytes.second_byte <= sync_data_i;
      pix_hcount_o                 <= col;
      pix_vcount_o                 <= row;
    end
  end

endmodule

`default_nettype wire

//--- src/chroma_key_mask.sv
`default_nettype none

`include "tracker_cfg.svh"

module chroma_key_mask (
  input  wire                     clk_camera,
  input  wire                     recent_reset,
  input  wire                     pix_valid_i,
  input  wire tracker_pkg::cam_pixel_u pix_data_i,
  input  wire tracker_pkg::hcount_t    pix_hcount_i,
  input  wire tracker_pkg::vcount_t    pix_vcount_i,
  input  wire  [3:0]              green_lower_i,
  input  wire  [1:0]              rb_shift_i,
  output logic                    mask_valid_o,
  output logic                    mask_is_player_o,
  output tracker_pkg::hcount_t    mask_hcount_o,
  output tracker_pkg::vcount_t    mask_vcount_o
);

  import tracker_pkg::*;

  rgb565_t    px;
  // channels on an 8-bit scale
  logic [7:0] red8;
  logic [7:0] green8;
  logic [7:0] blue8;
  logic [7:0] green_floor;
  logic       is_green;

  // same word the builder wrote as bytes, read here as colors
  assign px          = pix_data_i.color;
  assign red8        = {px.red, 3'b000};
  assign green8      = {px.green, 2'b00};
  assign blue8       = {px.blue, 3'b000};
  assign green_floor = {green_lower_i, 4'b0000};

  // green inside its window and dominant over red and blue
  assign is_green = (green8 >= green_floor) &&
                    (green8 <= `TRACKER_GREEN_CEIL) &&
                    (green8 > (red8 >> rb_shift_i)) &&
                    (green8 > (blue8 >> rb_shift_i));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mask_valid_o <= 1'b0;
    end else begin
      mask_valid_o <= pix_valid_i;
    end
  end

  // anything not green screen counts as player
  always_ff @(posedge clk_camera) begin
    mask_is_player_o <= ~is_green;
    mask_hcount_o    <= pix_hcount_i;
    mask_vcount_o    <= pix_vcount_i;
  end

endmodule

`default_nettype wire

//--- src/centroid_accumulator.sv
`default_nettype none

`include "tracker_cfg.svh"

module centroid_accumulator (
  input  wire                  clk_camera,
  input  wire                  recent_reset,
  input  wire                  mask_valid_i,
  input  wire                  mask_is_player_i,
  input  wire tracker_pkg::hcount_t mask_hcount_i,
  input  wire tracker_pkg::vcount_t mask_vcount_i,
  input  wire                  frame_end_i,
  output tracker_pkg::hcount_t com_x_o,
  output tracker_pkg::vcount_t com_y_o,
  output logic                 com_valid_o
);

  import tracker_pkg::*;

  localparam int SUM_W = `TRACKER_SUM_W;
  localparam int HW    = `TRACKER_HCOUNT_W;
  localparam int VW    = `TRACKER_VCOUNT_W;
  localparam int IDX_W = $clog2(HW);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_DIV_X  = 2'd1;
  localparam logic [1:0] ST_DIV_Y  = 2'd2;
  localparam logic [1:0] ST_FINISH = 2'd3;

  // running sums of the frame being received
  logic [SUM_W-1:0]    acc_x;
  logic [SUM_W-1:0]    acc_y;
  logic [SUM_W-1:0]    acc_n;
  // frame being divided
  logic [SUM_W-1:0]    lat_y;
  logic [SUM_W-1:0]    lat_n;
  logic [SUM_W-1:0]    rem;
  logic [1:0]          state;
  logic [IDX_W-1:0]    bit_idx;
  hcount_t             quo;
  hcount_t             x_res;
  // one restoring step
  logic [SUM_W+HW-1:0] div_shifted;
  logic [SUM_W+HW-1:0] rem_wide;
  logic                fits;
  hcount_t             quo_next;
  logic [SUM_W-1:0]    rem_next;

  // ==========================================================================
  // per-frame accumulation
  // ==========================================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      acc_x <= '0;
      acc_y <= '0;
      acc_n <= '0;
    end else if (frame_end_i) begin
      // new frame starts even if the divider is still busy
      acc_x <= '0;
      acc_y <= '0;
      acc_n <= '0;
    end else if (mask_valid_i && mask_is_player_i) begin
      acc_x <= acc_x + SUM_W'(mask_hcount_i);
      acc_y <= acc_y + SUM_W'(mask_vcount_i);
      acc_n <= acc_n + 1'b1;
    end
  end

  // ==========================================================================
  // shared restoring divider, x then y
  // ==========================================================================

  // the mean is below 2**HW, so only the low quotient bits are worked
  // trial subtract of the count shifted to the current quotient bit
  always_comb begin
    div_shifted = {{HW{1'b0}}, lat_n} << bit_idx;
    rem_wide    = {{HW{1'b0}}, rem};
    fits        = rem_wide >= div_shifted;
    quo_next    = quo;
    rem_next    = rem;
    if (fits) begin
      quo_next[bit_idx] = 1'b1;
      rem_next          = rem - div_shifted[SUM_W-1:0];
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state       <= ST_IDLE;
      bit_idx     <= '0;
      com_x_o     <= '0;
      com_y_o     <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          // too few pixels, keep the old centroid
          if (frame_end_i && acc_n >= SUM_W'(`TRACKER_MIN_PIXELS)) begin
            state   <= ST_DIV_X;
            bit_idx <= IDX_W'(HW - 1);
          end
        end
        ST_DIV_X: begin
          if (bit_idx == '0) begin
            state   <= ST_DIV_Y;
            bit_idx <= IDX_W'(VW - 1);
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end
        ST_DIV_Y: begin
          if (bit_idx == '0) begin
            state <= ST_FINISH;
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end
        ST_FINISH: begin
          com_x_o     <= x_res;
          com_y_o     <= quo[VW-1:0];
          com_valid_o <= 1'b1;
          state       <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // divider datapath
  always_ff @(posedge clk_camera) begin
    case (state)
      ST_IDLE: begin
        if (frame_end_i) begin
          rem   <= acc_x;
          lat_y <= acc_y;
          lat_n <= acc_n;
          quo   <= '0;
        end
      end
      ST_DIV_X: begin
        rem <= rem_next;
        quo <= quo_next;
        // x done, reload for y
        if (bit_idx == '0) begin
          x_res <= quo_next;
          rem   <= lat_y;
          quo   <= '0;
        end
      end
      ST_DIV_Y: begin
        rem <= rem_next;
        quo <= quo_next;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/camera_tracker_top.sv
`default_nettype none

module camera_tracker_top (
  input  wire                  clk_camera,
  input  wire                  recent_reset,
  input  wire  [7:0]           cam_data_i,
  input  wire                  cam_pclk_i,
  input  wire                  cam_hsync_i,
  input  wire                  cam_vsync_i,
  input  wire  [3:0]           green_lower_i,
  input  wire  [1:0]           rb_shift_i,
  output logic                 pix_valid_o,
  output logic [15:0]          pix_data_o,
  output logic                 mask_valid_o,
  output logic                 pix_is_player_o,
  output tracker_pkg::hcount_t com_x_o,
  output tracker_pkg::vcount_t com_y_o,
  output logic                 com_valid_o
);

  import tracker_pkg::*;

  // ==========================================================================
  // stage wiring
  // ==========================================================================

  // synchronized camera bus
  logic [7:0] sync_data;
  logic       pclk_rise;
  logic       sync_hsync;
  logic       sync_vsync;
  // rebuilt pixels
  logic       pix_valid;
  cam_pixel_u pix_data;
  hcount_t    pix_hcount;
  vcount_t    pix_vcount;
  logic       frame_end;
  // keyed pixels
  logic       mask_valid;
  logic       mask_is_player;
  hcount_t    mask_hcount;
  vcount_t    mask_vcount;

  cam_input_sync u_sync (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_data_i   (cam_data_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .sync_data_o  (sync_data),
    .pclk_rise_o  (pclk_rise),
    .sync_hsync_o (sync_hsync),
    .sync_vsync_o (sync_vsync)
  );

  pixel_reconstruct u_pixel (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .sync_data_i  (sync_data),
    .pclk_rise_i  (pclk_rise),
    .sync_hsync_i (sync_hsync),
    .sync_vsync_i (sync_vsync),
    .pix_valid_o  (pix_valid),
    .pix_data_o   (pix_data),
    .pix_hcount_o (pix_hcount),
    .pix_vcount_o (pix_vcount),
    .frame_end_o  (frame_end)
  );

  chroma_key_mask u_mask (
    .clk_camera       (clk_camera),
    .recent_reset     (recent_reset),
    .pix_valid_i      (pix_valid),
    .pix_data_i       (pix_data),
    .pix_hcount_i     (pix_hcount),
    .pix_vcount_i     (pix_vcount),
    .green_lower_i    (green_lower_i),
    .rb_shift_i       (rb_shift_i),
    .mask_valid_o     (mask_valid),
    .mask_is_player_o (mask_is_player),
    .mask_hcount_o    (mask_hcount),
    .mask_vcount_o    (mask_vcount)
  );

  centroid_accumulator u_centroid (
    .clk_camera       (clk_camera),
    .recent_reset     (recent_reset),
    .mask_valid_i     (mask_valid),
    .mask_is_player_i (mask_is_player),
    .mask_hcount_i    (mask_hcount),
    .mask_vcount_i    (mask_vcount),
    .frame_end_i      (frame_end),
    .com_x_o          (com_x_o),
    .com_y_o          (com_y_o),
    .com_valid_o      (com_valid_o)
  );

  // pixel tap for observing the stream
  assign pix_valid_o     = pix_valid;
  assign pix_data_o      = pix_data;
  assign mask_valid_o    = mask_valid;
  assign pix_is_player_o = mask_is_player;

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_camera_o,
  output logic recent_reset_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 8 ns camera clock
  initial begin
    clk_camera_o = 1'b0;
    forever #4 clk_camera_o = ~clk_camera_o;
  end

  // reset held high for the first cycles, released on a rising edge
  initial begin
    recent_reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_camera_o);
    recent_reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
`default_nettype none

`include "tracker_cfg.svh"

module tb_checker #(
  parameter int LINE_PIXELS = 24
) (
  input  wire                  clk_camera_i,
  input  wire                  recent_reset_i,
  input  wire  [7:0]           cam_data_i,
  input  wire                  cam_pclk_i,
  input  wire                  cam_hsync_i,
  input  wire                  cam_vsync_i,
  input  wire  [3:0]           green_lower_i,
  input  wire  [1:0]           rb_shift_i,
  input  wire                  pix_valid_i,
  input  wire  [15:0]          pix_data_i,
  input  wire                  mask_valid_i,
  input  wire                  pix_is_player_i,
  input  wire tracker_pkg::hcount_t com_x_i,
  input  wire tracker_pkg::vcount_t com_y_i,
  input  wire                  com_valid_i,
  input  wire                  run_done_i,
  output int                   error_count_o,
  output logic                 summary_done_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // expected stream in camera order
  logic [15:0] pix_queue [$];
  logic        player_queue [$];
  int unsigned com_x_queue [$];
  int unsigned com_y_queue [$];
  // camera pin history
  logic        pclk_prev;
  logic        hs_prev;
  logic        vs_prev;
  logic        phase;
  logic [7:0]  hi_byte;
  int unsigned col;
  int unsigned row;
  // reference sums of the frame on the pins
  int unsigned sum_x;
  int unsigned sum_y;
  int unsigned n_player;
  logic        frame_open;
  logic        line_pending;
  int unsigned line_strobes;
  // centroid the DUT must hold between pulses
  int unsigned held_x;
  int unsigned held_y;
  int unsigned pix_checks;
  int unsigned mask_checks;
  int unsigned com_checks;

  // ==========================================================================
  // reference model
  // ==========================================================================

  // high byte arrives first
  function automatic logic [15:0] pixel_ref(input logic [7:0] hi, input logic [7:0] lo);
    return {hi, lo};
  endfunction

  function automatic logic player_ref(input logic [15:0] px, input logic [3:0] lower,
                                      input logic [1:0] shift);
    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
    logic       green;
    r8 = {px[15:11], 3'b000};
    g8 = {px[10:5], 2'b00};
    b8 = {px[4:0], 3'b000};
    green = (g8 >= {lower, 4'b0000}) && (g8 <= `TRACKER_GREEN_CEIL) &&
            (g8 > (r8 >> shift)) && (g8 > (b8 >> shift));
    return !green;
  endfunction

  // truncating mean
  function automatic int unsigned centroid_ref(input int unsigned sum, input int unsigned n);
    return sum / n;
  endfunction

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
    error_count_o++;
  endtask

  task automatic report_problem(input string what);
    $display("Error: %s", what);
    error_count_o++;
  endtask

  task automatic close_line();
    if (line_pending) begin
      if (line_strobes != LINE_PIXELS) begin
        fail_value("pix_valid_o strobes per line", LINE_PIXELS, line_strobes);
      end
      line_pending = 1'b0;
    end
    line_strobes = 0;
  endtask

  // previous frame must have delivered its pulse before this one ends
  task automatic close_frame();
    if (frame_open) begin
      if (com_x_queue.size() != 0) begin
        report_problem("no com_valid_o pulse arrived before the next frame ended");
        com_x_queue.delete();
        com_y_queue.delete();
      end
      if (n_player >= `TRACKER_MIN_PIXELS) begin
        com_x_queue.push_back(centroid_ref(sum_x, n_player));
        com_y_queue.push_back(centroid_ref(sum_y, n_player));
      end
    end
    frame_open = 1'b1;
    sum_x      = 0;
    sum_y      = 0;
    n_player   = 0;
  endtask

  // framing rule applied to the pins
  task automatic track_camera_pins();
    logic [15:0] px;
    logic        player;
    if (cam_vsync_i && !vs_prev) begin
      close_line();
      close_frame();
      row = 0;
    end
    if (cam_hsync_i && !hs_prev) begin
      close_line();
      col   = 0;
      phase = 1'b0;
    end
    if (!cam_hsync_i && hs_prev) begin
      row++;
      line_pending = 1'b1;
    end
    if (cam_pclk_i && !pclk_prev && cam_hsync_i && !cam_vsync_i) begin
      if (!phase) begin
        hi_byte = cam_data_i;
        phase   = 1'b1;
      end else begin
        px     = pixel_ref(hi_byte, cam_data_i);
        player = player_ref(px, green_lower_i, rb_shift_i);
        pix_queue.push_back(px);
        player_queue.push_back(player);
        if (player) begin
          sum_x += col;
          sum_y += row;
          n_player++;
        end
        col++;
        phase = 1'b0;
      end
    end
    pclk_prev = cam_pclk_i;
    hs_prev   = cam_hsync_i;
    vs_prev   = cam_vsync_i;
  endtask

  // ==========================================================================
  // DUT output checks
  // ==========================================================================

  task automatic check_outputs();
    logic [15:0] exp_px;
    logic        exp_player;
    int unsigned exp_x;
    int unsigned exp_y;
    if (pix_valid_i === 1'b1) begin
      line_strobes++;
      if (pix_queue.size() == 0) begin
        report_problem("pix_valid_o strobed with no pixel sent on the camera bus");
      end else begin
        exp_px = pix_queue.pop_front();
        pix_checks++;
        if (pix_data_i !== exp_px) fail_value("pix_data_o", exp_px, pix_data_i);
      end
    end
    if (mask_valid_i === 1'b1) begin
      if (player_queue.size() == 0) begin
        report_problem("mask_valid_o strobed with no pixel pending");
      end else begin
        exp_player = player_queue.pop_front();
        mask_checks++;
        if (pix_is_player_i !== exp_player) begin
          fail_value("pix_is_player_o", exp_player, pix_is_player_i);
        end
      end
    end
    if (com_valid_i === 1'b1) begin
      if (com_x_queue.size() == 0) begin
        report_problem("com_valid_o pulsed with no centroid expected");
        held_x = com_x_i;
        held_y = com_y_i;
      end else begin
        exp_x = com_x_queue.pop_front();
        exp_y = com_y_queue.pop_front();
        com_checks++;
        if (com_x_i !== exp_x[10:0]) fail_value("com_x_o", exp_x, com_x_i);
        if (com_y_i !== exp_y[9:0]) fail_value("com_y_o", exp_y, com_y_i);
        held_x = exp_x;
        held_y = exp_y;
      end
    end else begin
      // between pulses the centroid stays put
      if (com_x_i !== held_x[10:0]) fail_value("com_x_o", held_x, com_x_i);
      if (com_y_i !== held_y[9:0]) fail_value("com_y_o", held_y, com_y_i);
    end
  endtask

  task automatic finish_checks();
    close_line();
    if (pix_queue.size() != 0) begin
      report_problem($sformatf("%0d sent pixels never came out on pix_valid_o",
                               pix_queue.size()));
    end
    if (player_queue.size() != 0) begin
      report_problem($sformatf("%0d pixels never came out on mask_valid_o",
                               player_queue.size()));
    end
    if (com_x_queue.size() != 0) begin
      report_problem("the last frame never produced its com_valid_o pulse");
    end
    $display("checked %0d pixels, %0d mask bits, %0d centroids, %0d errors",
             pix_checks, mask_checks, com_checks, error_count_o);
    summary_done_o = 1'b1;
  endtask

  always @(posedge clk_camera_i) begin
    if (recent_reset_i) begin
      pix_queue.delete();
      player_queue.delete();
      com_x_queue.delete();
      com_y_queue.delete();
      pclk_prev      = 1'b0;
      hs_prev        = 1'b0;
      vs_prev        = 1'b0;
      phase          = 1'b0;
      hi_byte        = 8'h00;
      col            = 0;
      row            = 0;
      sum_x          = 0;
      sum_y          = 0;
      n_player       = 0;
      frame_open     = 1'b0;
      line_pending   = 1'b0;
      line_strobes   = 0;
      held_x         = 0;
      held_y         = 0;
      pix_checks     = 0;
      mask_checks    = 0;
      com_checks     = 0;
      error_count_o  = 0;
      summary_done_o = 1'b0;
    end else if (!summary_done_o) begin
      track_camera_pins();
      check_outputs();
      if (run_done_i) begin
        finish_checks();
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
`default_nettype none

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  // camera frame geometry and pixel clock divide
  localparam int FRAME_W         = 24;
  localparam int FRAME_H         = 16;
  localparam int PCLK_DIV        = 4;
  localparam int FRAMES          = 5;
  localparam int VSYNC_LEN       = 3;
  localparam int VSYNC_GAP       = 3;
  localparam int LINE_GAP        = 4;
  localparam int ALL_GREEN_FRAME = 2;
  localparam int DRAIN_CYCLES    = 64;
  localparam int FRAME_CYCLES    =
    PCLK_DIV * (VSYNC_LEN + VSYNC_GAP + FRAME_H * (2 * FRAME_W + LINE_GAP));
  localparam int TIMEOUT_CYCLES  = 2 * FRAMES * FRAME_CYCLES;

  logic                 clk_camera;
  logic                 recent_reset;
  // camera pins and keyer settings
  logic [7:0]           cam_data;
  logic                 cam_pclk;
  logic                 cam_hsync;
  logic                 cam_vsync;
  logic [3:0]           green_lower;
  logic [1:0]           rb_shift;
  // DUT outputs
  logic                 pix_valid;
  logic [15:0]          pix_data;
  logic                 mask_valid;
  logic                 pix_is_player;
  tracker_pkg::hcount_t com_x;
  tracker_pkg::vcount_t com_y;
  logic                 com_valid;
  // end of run handshake with the checker
  logic                 run_done;
  logic                 summary_done;
  int                   error_count;

  tb_clock_gen #(.RESET_CYCLES(8)) u_clock_gen (
    .clk_camera_o   (clk_camera),
    .recent_reset_o (recent_reset)
  );

  camera_tracker_top dut (
    .clk_camera      (clk_camera),
    .recent_reset    (recent_reset),
    .cam_data_i      (cam_data),
    .cam_pclk_i      (cam_pclk),
    .cam_hsync_i     (cam_hsync),
    .cam_vsync_i     (cam_vsync),
    .green_lower_i   (green_lower),
    .rb_shift_i      (rb_shift),
    .pix_valid_o     (pix_valid),
    .pix_data_o      (pix_data),
    .mask_valid_o    (mask_valid),
    .pix_is_player_o (pix_is_player),
    .com_x_o         (com_x),
    .com_y_o         (com_y),
    .com_valid_o     (com_valid)
  );

  tb_checker #(.LINE_PIXELS(FRAME_W)) u_checker (
    .clk_camera_i    (clk_camera),
    .recent_reset_i  (recent_reset),
    .cam_data_i      (cam_data),
    .cam_pclk_i      (cam_pclk),
    .cam_hsync_i     (cam_hsync),
    .cam_vsync_i     (cam_vsync),
    .green_lower_i   (green_lower),
    .rb_shift_i      (rb_shift),
    .pix_valid_i     (pix_valid),
    .pix_data_i      (pix_data),
    .mask_valid_i    (mask_valid),
    .pix_is_player_i (pix_is_player),
    .com_x_i         (com_x),
    .com_y_i         (com_y),
    .com_valid_i     (com_valid),
    .run_done_i      (run_done),
    .error_count_o   (error_count),
    .summary_done_o  (summary_done)
  );

  // ==========================================================================
  // camera model
  // ==========================================================================

  // one pixel clock period with the pins changing on the low half
  task automatic drive_pclk_cycle(input logic [7:0] data, input logic hs, input logic vs);
    cam_pclk  <= 1'b0;
    cam_data  <= data;
    cam_hsync <= hs;
    cam_vsync <= vs;
    repeat (PCLK_DIV / 2) @(posedge clk_camera);
    cam_pclk  <= 1'b1;
    repeat (PCLK_DIV / 2) @(posedge clk_camera);
  endtask

  // three in four pixels lean toward green screen
  function automatic logic [15:0] random_pixel();
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    if ($urandom_range(3) != 0) begin
      red   = 5'($urandom_range(15));
      green = 6'($urandom_range(62, 24));
      blue  = 5'($urandom_range(15));
    end else begin
      red   = 5'($urandom_range(31));
      green = 6'($urandom_range(63));
      blue  = 5'($urandom_range(31));
    end
    return {red, green, blue};
  endfunction

  // vsync pulse whose rising edge closes the previous frame
  task automatic send_vsync();
    repeat (VSYNC_LEN) drive_pclk_cycle(8'h00, 1'b0, 1'b1);
    repeat (VSYNC_GAP) drive_pclk_cycle(8'h00, 1'b0, 1'b0);
  endtask

  task automatic send_frame(input logic all_green);
    logic [15:0] px;
    for (int row = 0; row < FRAME_H; row++) begin
      for (int col = 0; col < FRAME_W; col++) begin
        // g=50 with r=b=0 stays green under the settings of that frame
        px = all_green ? 16'h0640 : random_pixel();
        drive_pclk_cycle(px[15:8], 1'b1, 1'b0);
        drive_pclk_cycle(px[7:0], 1'b1, 1'b0);
      end
      repeat (LINE_GAP) drive_pclk_cycle(8'h00, 1'b0, 1'b0);
    end
  endtask

  initial begin
    void'($urandom(59));
    cam_data    <= 8'h00;
    cam_pclk    <= 1'b0;
    cam_hsync   <= 1'b0;
    cam_vsync   <= 1'b0;
    green_lower <= 4'd8;
    rb_shift    <= 2'd1;
    run_done    <= 1'b0;
    @(posedge clk_camera);
    while (recent_reset) @(posedge clk_camera);
    // quiet bus so the outputs must stay idle here
    repeat (40) @(posedge clk_camera);
    for (int f = 0; f < FRAMES; f++) begin
      if (f == ALL_GREEN_FRAME) begin
        green_lower <= 4'd4;
        rb_shift    <= 2'd0;
      end else begin
        green_lower <= 4'($urandom_range(12));
        rb_shift    <= 2'($urandom_range(3));
      end
      send_vsync();
      send_frame(f == ALL_GREEN_FRAME);
    end
    // ends the last frame
    send_vsync();
    repeat (DRAIN_CYCLES) @(posedge clk_camera);
    run_done <= 1'b1;
    @(posedge clk_camera);
    while (!summary_done) @(posedge clk_camera);
    @(posedge clk_camera);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog at twice the length of all frames
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_camera);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/tracker_pkg.sv
src/cam_input_sync.sv
src/pixel_reconstruct.sv
src/chroma_key_mask.sv
src/centroid_accumulator.sv
src/camera_tracker_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv
